/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // Major opcodes in instr[6:0].
    localparam logic [6:0] OP     = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] LUI    = 7'b0110111;
    localparam logic [6:0] AUIPC  = 7'b0010111;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;
    localparam logic [6:0] BRANCH = 7'b1100011;

    // ALU funct3 selectors for OP and OP_IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // Selects SUB and SRA.

endpackage

/* src/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef struct packed {
        logic a_pc;   // Operand A is the pc instead of rs1.
        logic b_imm;  // Operand B is the immediate instead of rs2.
    } alu_src_t;

    typedef enum logic [1:0] {
        RES_ALU, RES_PC_PLUS4, RES_NONE
    } result_src_t;

    typedef enum logic [2:0] {
        BJ_NONE, BJ_BEQ, BJ_BNE, BJ_BLT, BJ_BGE, BJ_BLTU, BJ_BGEU, BJ_JUMP
    } branch_jump_t;

endpackage

/* src/decode_ctrl.sv */
`timescale 1ns/100ps

module decode_ctrl import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    output logic [REG_ADDR_WIDTH-1:0] rs1,
    output logic [REG_ADDR_WIDTH-1:0] rs2,
    output logic [REG_ADDR_WIDTH-1:0] rd,
    output logic [DATA_WIDTH-1:0]     imm_ext,
    output logic                      valid,
    output logic                      reg_write,
    output logic                      jump_reg,
    output result_src_t               result_src,
    output alu_op_t                   alu_ctrl,
    output alu_src_t                  alu_src,
    output branch_jump_t              branch_jump
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  legal;
    logic                  writes_rd;
    logic [DATA_WIDTH-1:0] imm_i;
    logic [DATA_WIDTH-1:0] imm_b;
    logic [DATA_WIDTH-1:0] imm_u;
    logic [DATA_WIDTH-1:0] imm_j;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        alu_sel = ALU_ADD;
        case (f3)
            F3_ADD_SUB: begin
                if (alt)
                    alu_sel = ALU_SUB;
            end
            F3_SLL:     alu_sel = ALU_SLL;
            F3_SLT:     alu_sel = ALU_SLT;
            F3_SLTU:    alu_sel = ALU_SLTU;
            F3_XOR:     alu_sel = ALU_XOR;
            F3_SRL_SRA: begin
                if (alt)
                    alu_sel = ALU_SRA;
                else
                    alu_sel = ALU_SRL;
            end
            F3_OR:      alu_sel = ALU_OR;
            F3_AND:     alu_sel = ALU_AND;
        endcase
    endfunction

    function automatic branch_jump_t branch_sel(input logic [2:0] f3);
        branch_sel = BJ_NONE;  // funct3 010 and 011 are not branches.
        case (f3)
            F3_BEQ:  branch_sel = BJ_BEQ;
            F3_BNE:  branch_sel = BJ_BNE;
            F3_BLT:  branch_sel = BJ_BLT;
            F3_BGE:  branch_sel = BJ_BGE;
            F3_BLTU: branch_sel = BJ_BLTU;
            F3_BGEU: branch_sel = BJ_BGEU;
            default: branch_sel = BJ_NONE;
        endcase
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        legal       = 1'b1;
        writes_rd   = 1'b1;
        result_src  = RES_ALU;
        alu_ctrl    = ALU_ADD;
        alu_src     = '{a_pc: 1'b0, b_imm: 1'b1};
        branch_jump = BJ_NONE;
        jump_reg    = 1'b0;
        imm_ext     = imm_i;
        case (opcode)
            OP: begin
                alu_src.b_imm = 1'b0;
                alu_ctrl      = alu_sel(funct3, funct7 == F7_ALT);
                legal         = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            end
            OP_IMM: alu_ctrl = alu_sel(funct3, (funct3 == F3_SRL_SRA) && (funct7 == F7_ALT));
            LUI: begin
                imm_ext  = imm_u;
                alu_ctrl = ALU_PASS_B;
            end
            AUIPC: begin
                imm_ext      = imm_u;
                alu_src.a_pc = 1'b1;
            end
            JAL: begin
                imm_ext     = imm_j;
                branch_jump = BJ_JUMP;
                result_src  = RES_PC_PLUS4;
            end
            JALR: begin
                branch_jump = BJ_JUMP;
                jump_reg    = 1'b1;
                result_src  = RES_PC_PLUS4;
            end
            BRANCH: begin
                imm_ext     = imm_b;
                writes_rd   = 1'b0;
                result_src  = RES_NONE;
                branch_jump = branch_sel(funct3);
                legal       = (branch_jump != BJ_NONE);
            end
            default: legal = 1'b0;
        endcase
        valid     = instr_valid && legal;
        reg_write = valid && writes_rd && (rd != '0);  // Writes to x0 are dropped here.
        if (!valid)
            branch_jump = BJ_NONE;
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/100ps

module reg_file import rv_isa_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [REG_ADDR_WIDTH-1:0] rs1,
    input  logic [REG_ADDR_WIDTH-1:0] rs2,
    input  logic                      we,
    input  logic [REG_ADDR_WIDTH-1:0] wa,
    input  logic [DATA_WIDTH-1:0]     wd,
    output logic [DATA_WIDTH-1:0]     read_data1,
    output logic [DATA_WIDTH-1:0]     read_data2
);

    logic [DATA_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // A write in this cycle is visible to a read of the same index.
    assign read_data1 = (rs1 == '0) ? '0 :
                        (we && (wa == rs1)) ? wd : regs[rs1];
    assign read_data2 = (rs2 == '0) ? '0 :
                        (we && (wa == rs2)) ? wd : regs[rs2];

endmodule

/* src/id_ex_reg.sv */
`timescale 1ns/100ps

module id_ex_reg import rv_isa_pkg::*, pipe_ctrl_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clr,
    input  logic [REG_ADDR_WIDTH-1:0] id_rs1,
    input  logic [REG_ADDR_WIDTH-1:0] id_rs2,
    input  logic [REG_ADDR_WIDTH-1:0] id_rd,
    input  logic [PC_WIDTH-1:0]       id_pc,
    input  logic [PC_WIDTH-1:0]       id_pc_plus4,
    input  logic [DATA_WIDTH-1:0]     id_imm_ext,
    input  logic [DATA_WIDTH-1:0]     id_read_data1,
    input  logic [DATA_WIDTH-1:0]     id_read_data2,
    input  logic                      id_valid,
    input  logic                      id_reg_write,
    input  result_src_t               id_result_src,
    input  alu_op_t                   id_alu_ctrl,
    input  alu_src_t                  id_alu_src,
    input  branch_jump_t              id_branch_jump,
    input  logic                      id_jump_reg,
    output logic [REG_ADDR_WIDTH-1:0] ex_rs1,
    output logic [REG_ADDR_WIDTH-1:0] ex_rs2,
    output logic [REG_ADDR_WIDTH-1:0] ex_rd,
    output logic [PC_WIDTH-1:0]       ex_pc,
    output logic [PC_WIDTH-1:0]       ex_pc_plus4,
    output logic [DATA_WIDTH-1:0]     ex_imm_ext,
    output logic [DATA_WIDTH-1:0]     ex_read_data1,
    output logic [DATA_WIDTH-1:0]     ex_read_data2,
    output logic                      ex_valid,
    output logic                      ex_reg_write,
    output result_src_t               ex_result_src,
    output alu_op_t                   ex_alu_ctrl,
    output alu_src_t                  ex_alu_src,
    output branch_jump_t              ex_branch_jump,
    output logic                      ex_jump_reg
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_rs1        <= '0;
            ex_rs2        <= '0;
            ex_rd         <= '0;
            ex_pc         <= '0;
            ex_pc_plus4   <= '0;
            ex_imm_ext    <= '0;
            ex_read_data1 <= '0;
            ex_read_data2 <= '0;
        end else begin
            ex_rs1        <= id_rs1;
            ex_rs2        <= id_rs2;
            ex_rd         <= id_rd;
            ex_pc         <= id_pc;
            ex_pc_plus4   <= id_pc_plus4;
            ex_imm_ext    <= id_imm_ext;
            ex_read_data1 <= id_read_data1;
            ex_read_data2 <= id_read_data2;
        end
    end

    // A flush turns the entering instruction into a bubble.
    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            ex_valid       <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_result_src  <= RES_NONE;
            ex_alu_ctrl    <= ALU_ADD;
            ex_alu_src     <= '0;
            ex_branch_jump <= BJ_NONE;
            ex_jump_reg    <= 1'b0;
        end else begin
            ex_valid       <= id_valid;
            ex_reg_write   <= id_reg_write;
            ex_result_src  <= id_result_src;
            ex_alu_ctrl    <= id_alu_ctrl;
            ex_alu_src     <= id_alu_src;
            ex_branch_jump <= id_branch_jump;
            ex_jump_reg    <= id_jump_reg;
        end
    end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import rv_isa_pkg::*, pipe_ctrl_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [REG_ADDR_WIDTH-1:0] rs1,
    input  logic [REG_ADDR_WIDTH-1:0] rs2,
    input  logic [REG_ADDR_WIDTH-1:0] rd,
    input  logic [PC_WIDTH-1:0]       pc,
    input  logic [PC_WIDTH-1:0]       pc_plus4,
    input  logic [DATA_WIDTH-1:0]     imm_ext,
    input  logic [DATA_WIDTH-1:0]     read_data1,
    input  logic [DATA_WIDTH-1:0]     read_data2,
    input  logic                      valid,
    input  logic                      reg_write,
    input  result_src_t               result_src,
    input  alu_op_t                   alu_ctrl,
    input  alu_src_t                  alu_src,
    input  branch_jump_t              branch_jump,
    input  logic                      jump_reg,
    output logic                      flush,
    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [DATA_WIDTH-1:0]     wb_data,
    output logic                      redirect,
    output logic [PC_WIDTH-1:0]       redirect_pc
);

    logic [DATA_WIDTH-1:0] val1;
    logic [DATA_WIDTH-1:0] val2;
    logic [DATA_WIDTH-1:0] op_a;
    logic [DATA_WIDTH-1:0] op_b;
    logic [4:0]            shamt;
    logic [DATA_WIDTH-1:0] alu_result;
    logic [DATA_WIDTH-1:0] target_sum;
    logic [PC_WIDTH-1:0]   target;
    logic                  taken;

    // The previous instruction's result has not reached the register file yet.
    assign val1 = (wb_valid && (wb_rd != '0) && (wb_rd == rs1)) ? wb_data : read_data1;
    assign val2 = (wb_valid && (wb_rd != '0) && (wb_rd == rs2)) ? wb_data : read_data2;

    assign op_a  = alu_src.a_pc ? DATA_WIDTH'(pc) : val1;
    assign op_b  = alu_src.b_imm ? imm_ext : val2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_ctrl)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = DATA_WIDTH'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = DATA_WIDTH'(op_a < op_b);
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    always_comb begin
        case (branch_jump)
            BJ_BEQ:  taken = (val1 == val2);
            BJ_BNE:  taken = (val1 != val2);
            BJ_BLT:  taken = ($signed(val1) < $signed(val2));
            BJ_BGE:  taken = ($signed(val1) >= $signed(val2));
            BJ_BLTU: taken = (val1 < val2);
            BJ_BGEU: taken = (val1 >= val2);
            BJ_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign target_sum = (jump_reg ? val1 : DATA_WIDTH'(pc)) + imm_ext;
    assign target     = PC_WIDTH'(target_sum) & ~PC_WIDTH'(jump_reg);  // JALR clears bit 0.
    assign flush      = valid && taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            redirect <= 1'b0;
        end else begin
            wb_valid <= valid && reg_write;
            redirect <= flush;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= rd;
        wb_data     <= (result_src == RES_PC_PLUS4) ? DATA_WIDTH'(pc_plus4) : alu_result;
        redirect_pc <= target;
    end

endmodule

/* src/int_core_slice.sv */
`timescale 1ns/100ps

module int_core_slice import rv_isa_pkg::*, pipe_ctrl_pkg::*; #(
    parameter int PC_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instr_valid,
    input  logic [31:0]               instr,
    input  logic [PC_WIDTH-1:0]       pc,
    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [DATA_WIDTH-1:0]     wb_data,
    output logic                      redirect,
    output logic [PC_WIDTH-1:0]       redirect_pc
);

    logic [REG_ADDR_WIDTH-1:0] id_rs1, id_rs2, id_rd;
    logic [REG_ADDR_WIDTH-1:0] ex_rs1, ex_rs2, ex_rd;
    logic [PC_WIDTH-1:0]       pc_plus4, ex_pc, ex_pc_plus4;
    logic [DATA_WIDTH-1:0]     id_imm_ext, id_read_data1, id_read_data2;
    logic [DATA_WIDTH-1:0]     ex_imm_ext, ex_read_data1, ex_read_data2;
    logic                      id_valid, id_reg_write, id_jump_reg;
    logic                      ex_valid, ex_reg_write, ex_jump_reg;
    logic                      flush;
    result_src_t               id_result_src, ex_result_src;
    alu_op_t                   id_alu_ctrl, ex_alu_ctrl;
    alu_src_t                  id_alu_src, ex_alu_src;
    branch_jump_t              id_branch_jump, ex_branch_jump;

    assign pc_plus4 = pc + PC_WIDTH'(4);

    decode_ctrl u_decode (
        .instr_valid(instr_valid), .instr(instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd),
        .imm_ext(id_imm_ext), .valid(id_valid), .reg_write(id_reg_write),
        .jump_reg(id_jump_reg), .result_src(id_result_src), .alu_ctrl(id_alu_ctrl),
        .alu_src(id_alu_src), .branch_jump(id_branch_jump)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n), .rs1(id_rs1), .rs2(id_rs2),
        .we(wb_valid), .wa(wb_rd), .wd(wb_data),  // Written back one cycle after EX.
        .read_data1(id_read_data1), .read_data2(id_read_data2)
    );

    id_ex_reg #(.PC_WIDTH(PC_WIDTH)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .clr(flush),
        .id_rs1(id_rs1), .id_rs2(id_rs2), .id_rd(id_rd), .id_pc(pc),
        .id_pc_plus4(pc_plus4), .id_imm_ext(id_imm_ext),
        .id_read_data1(id_read_data1), .id_read_data2(id_read_data2),
        .id_valid(id_valid), .id_reg_write(id_reg_write), .id_result_src(id_result_src),
        .id_alu_ctrl(id_alu_ctrl), .id_alu_src(id_alu_src),
        .id_branch_jump(id_branch_jump), .id_jump_reg(id_jump_reg),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd), .ex_pc(ex_pc),
        .ex_pc_plus4(ex_pc_plus4), .ex_imm_ext(ex_imm_ext),
        .ex_read_data1(ex_read_data1), .ex_read_data2(ex_read_data2),
        .ex_valid(ex_valid), .ex_reg_write(ex_reg_write), .ex_result_src(ex_result_src),
        .ex_alu_ctrl(ex_alu_ctrl), .ex_alu_src(ex_alu_src),
        .ex_branch_jump(ex_branch_jump), .ex_jump_reg(ex_jump_reg)
    );

    execute_stage #(.PC_WIDTH(PC_WIDTH)) u_execute (
        .clk(clk), .rst_n(rst_n), .rs1(ex_rs1), .rs2(ex_rs2), .rd(ex_rd), .pc(ex_pc),
        .pc_plus4(ex_pc_plus4), .imm_ext(ex_imm_ext),
        .read_data1(ex_read_data1), .read_data2(ex_read_data2),
        .valid(ex_valid), .reg_write(ex_reg_write), .result_src(ex_result_src),
        .alu_ctrl(ex_alu_ctrl), .alu_src(ex_alu_src), .branch_jump(ex_branch_jump),
        .jump_reg(ex_jump_reg), .flush(flush), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .wb_data(wb_data), .redirect(redirect), .redirect_pc(redirect_pc)
    );

endmodule

/* tb/slice_checker.sv */
`timescale 1ns/100ps

module slice_checker (
    input  logic        clk,
    input  logic        check_en,
    input  logic        finish_req,
    input  logic [7:0]  test_num,
    input  logic        exp_wb_valid,
    input  logic [4:0]  exp_wb_rd,
    input  logic [31:0] exp_wb_data,
    input  logic        exp_redirect,
    input  logic [31:0] exp_redirect_pc,
    input  logic        wb_valid,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        done,
    output int          error_count,
    output int          tests_passed,
    output int          tests_failed
);

    int cur_test;
    int test_errors;

    initial begin
        done         = 1'b0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = -1;
        test_errors  = 0;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_test();
        if (test_errors == 0) begin
            $display("Test %0d: pass", cur_test);
            tests_passed++;
        end else begin
            $display("Test %0d: fail with %0d mismatches", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // Sampled values at the edge are the outputs of the cycle that just ended.
    always @(posedge clk) begin
        if (check_en) begin
            if (int'(test_num) != cur_test) begin
                if (cur_test >= 0)
                    report_test();
                cur_test    = int'(test_num);
                test_errors = 0;
            end
            compare_value("wb_valid", 32'(wb_valid), 32'(exp_wb_valid));
            if (exp_wb_valid) begin  // rd and data only mean something on a write.
                compare_value("wb_rd", 32'(wb_rd), 32'(exp_wb_rd));
                compare_value("wb_data", wb_data, exp_wb_data);
            end
            compare_value("redirect", 32'(redirect), 32'(exp_redirect));
            if (exp_redirect)
                compare_value("redirect_pc", redirect_pc, exp_redirect_pc);
        end else if (finish_req && !done) begin
            if (cur_test >= 0)
                report_test();
            cur_test = -1;
            done     = 1'b1;
        end
    end

endmodule

/* tb/tb_int_core_slice.sv */
`timescale 1ns/100ps

module tb_int_core_slice;

    localparam int PC_WIDTH     = 32;
    localparam int MAX_LINES    = 64;
    localparam int FIELDS       = 9;  // Words per trace line.
    localparam int RESET_CYCLES = 8;

    logic                clk;
    logic                rst_n;
    logic                instr_valid;
    logic [31:0]         instr;
    logic [PC_WIDTH-1:0] pc;
    logic                wb_valid;
    logic [4:0]          wb_rd;
    logic [31:0]         wb_data;
    logic                redirect;
    logic [PC_WIDTH-1:0] redirect_pc;

    logic                check_en;
    logic                finish_req;
    logic [7:0]          test_num;
    logic                exp_wb_valid;
    logic [4:0]          exp_wb_rd;
    logic [31:0]         exp_wb_data;
    logic                exp_redirect;
    logic [PC_WIDTH-1:0] exp_redirect_pc;
    logic                checks_done;
    int                  error_count;
    int                  tests_passed;
    int                  tests_failed;

    logic [31:0] trace_mem [MAX_LINES*FIELDS];
    int          n_lines;
    int          cycle_count = 0;
    int          timeout_limit = 0;

    int_core_slice #(.PC_WIDTH(PC_WIDTH)) int_core_slice_inst (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    slice_checker u_checker (
        .clk(clk), .check_en(check_en), .finish_req(finish_req), .test_num(test_num),
        .exp_wb_valid(exp_wb_valid), .exp_wb_rd(exp_wb_rd), .exp_wb_data(exp_wb_data),
        .exp_redirect(exp_redirect), .exp_redirect_pc(exp_redirect_pc),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .done(checks_done), .error_count(error_count),
        .tests_passed(tests_passed), .tests_failed(tests_failed)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", timeout_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Puts one trace line on the DUT inputs and the expected-value wires.
    task automatic apply_line(input int idx);
        int base;
        base            = idx * FIELDS;
        test_num        = trace_mem[base][7:0];
        instr_valid     = trace_mem[base+1][0];
        instr           = trace_mem[base+2];
        pc              = trace_mem[base+3];
        exp_wb_valid    = trace_mem[base+4][0];
        exp_wb_rd       = trace_mem[base+5][4:0];
        exp_wb_data     = trace_mem[base+6];
        exp_redirect    = trace_mem[base+7][0];
        exp_redirect_pc = trace_mem[base+8];
        check_en        = 1'b1;
    endtask

    initial begin
        rst_n           = 1'b0;
        instr_valid     = 1'b0;
        instr           = '0;
        pc              = '0;
        check_en        = 1'b0;
        finish_req      = 1'b0;
        test_num        = '0;
        exp_wb_valid    = 1'b0;
        exp_wb_rd       = '0;
        exp_wb_data     = '0;
        exp_redirect    = 1'b0;
        exp_redirect_pc = '0;
        for (int i = 0; i < MAX_LINES*FIELDS; i++) begin
            trace_mem[i] = {8'hff, 24'(i)};  // The top byte marks an unfilled entry.
        end
        $readmemh("tb/slice_trace.txt", trace_mem);
        n_lines = 0;
        while (n_lines < MAX_LINES && trace_mem[n_lines*FIELDS][31:24] != 8'hff) begin
            n_lines++;
        end
        timeout_limit = n_lines + RESET_CYCLES + 20;
        if (n_lines == 0) begin
            $display("The trace file holds no lines.");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            #10;
            rst_n = 1'b1;
            apply_line(0);
            for (int i = 1; i < n_lines; i++) begin
                @(posedge clk);
                #10;
                apply_line(i);
            end
            @(posedge clk);
            #10;
            check_en    = 1'b0;
            instr_valid = 1'b0;
            finish_req  = 1'b1;
            wait (checks_done);
            $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                     tests_passed, tests_failed, error_count);
            if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
                $display("TESTBENCH PASSED");
            end else begin
                $display("TESTBENCH FAILED");
            end
            $finish;
        end
    end

endmodule

/* int_core_slice.f */
src/rv_isa_pkg.sv
src/pipe_ctrl_pkg.sv
src/decode_ctrl.sv
src/reg_file.sv
src/id_ex_reg.sv
src/execute_stage.sv
src/int_core_slice.sv
tb/slice_checker.sv
tb/tb_int_core_slice.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_int_core_slice \
    -f int_core_slice.f --Mdir obj_dir -o sim_int_core_slice &&
./obj_dir/sim_int_core_slice | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "Simulation result: pass" ||
{ echo "Simulation result: fail"; exit 1; }

/* tb/slice_trace.txt */
// test valid instr pc | exp: wb_valid wb_rd wb_data redirect redirect_pc
// Expected columns belong to the instruction two lines earlier.
01 0 00000000 00000000 0 00 00000000 0 00000000
01 0 00000000 00000000 0 00 00000000 0 00000000
02 1 00500093 00000100 0 00 00000000 0 00000000
02 1 ffd00113 00000104 0 00 00000000 0 00000000
02 1 123451b7 00000108 1 01 00000005 0 00000000
02 1 00700013 0000010c 1 02 fffffffd 0 00000000
02 1 00208233 00000110 1 03 12345000 0 00000000
02 1 402082b3 00000114 0 00 00000000 0 00000000
02 1 00112333 00000118 1 04 00000002 0 00000000
02 1 001133b3 0000011c 1 05 00000008 0 00000000
02 1 40115413 00000120 1 06 00000001 0 00000000
02 1 01c15493 00000124 1 07 00000000 0 00000000
02 1 00409513 00000128 1 08 fffffffe 0 00000000
02 1 0ff1c593 0000012c 1 09 0000000f 0 00000000
02 1 0030e633 00000130 1 0a 00000050 0 00000000
02 1 0f017693 00000134 1 0b 123450ff 0 00000000
03 1 01000713 00000138 1 0c 12345005 0 00000000
03 1 00e707b3 0000013c 1 0d 000000f0 0 00000000
03 1 00e78833 00000140 1 0e 00000010 0 00000000
03 1 40f808b3 00000144 1 0f 00000020 0 00000000
04 1 01170463 00000148 1 10 00000030 0 00000000
04 1 00100913 0000014c 1 11 00000010 0 00000000
04 1 010009ef 00000150 0 00 00000000 1 00000150
04 1 00200a13 00000154 0 00 00000000 0 00000000
04 1 02198ae7 00000160 1 13 00000154 1 00000160
04 1 00300b13 00000164 0 00 00000000 0 00000000
05 1 01171463 00000174 1 15 00000164 1 00000174
05 1 00900b93 00000178 0 00 00000000 0 00000000
05 1 0020c463 0000017c 0 00 00000000 0 00000000
05 1 0020f463 00000180 1 17 00000009 0 00000000
05 1 001b8c13 00000184 0 00 00000000 0 00000000
06 0 00100c93 00000188 0 00 00000000 0 00000000
06 1 ffffffff 00000188 1 18 0000000a 0 00000000
06 0 00000000 0000018c 0 00 00000000 0 00000000
06 0 00000000 0000018c 0 00 00000000 0 00000000
